/* Makefile */
# Verilator build and run of the fgp_tx testbench

VERILATOR ?= verilator
TOP       ?= fgp_tx_tb
FILELIST  ?= fgp_tx_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* fgp_tx_top.f */
source/fgp_tx_pkg.sv
source/packet_buffer_if.sv
source/packet_assembler.sv
source/packet_buffer.sv
source/eth_tx_framer.sv
source/fgp_tx_top.sv
test/fgp_tx_checker.sv
test/fgp_tx_tb.sv

/* source/eth_tx_framer.sv */
`timescale 1ns/1ps

module eth_tx_framer
	import fgp_tx_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	pb_read_if.framer  rd,
	output logic       tx_en,
	output logic [1:0] txd
);

	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_PREAMBLE = 3'd1;
	localparam logic [2:0] ST_SFD      = 3'd2;
	localparam logic [2:0] ST_ETYPE    = 3'd3;
	localparam logic [2:0] ST_PAYLOAD  = 3'd4;
	localparam logic [2:0] ST_GAP      = 3'd5;

	// Byte positions inside the frame
	localparam int SFD_POS = PREAMBLE_LEN;
	localparam int ETYPE_POS = PREAMBLE_LEN + 1;
	localparam int PAYLOAD_POS = PREAMBLE_LEN + 3;

	localparam int POS_W = $clog2(FRAME_BYTES + 1);
	localparam int DIB_W = $clog2(DIBITS_PER_BYTE);
	localparam int GAP_LEN = 2;

	logic [2:0]       state;
	logic [2:0]       next_state;
	logic [POS_W-1:0] byte_pos;
	logic [POS_W-1:0] next_pos;
	logic [DIB_W-1:0] dibit;
	logic [7:0]       shreg;
	logic [7:0]       next_byte;
	logic             byte_end;
	logic             release_q;

	assign byte_end = dibit == DIB_W'(DIBITS_PER_BYTE - 1);
	assign next_pos = byte_pos + 1'b1;

	// Which byte follows the current one, and in which state
	always_comb begin
		next_byte = PREAMBLE_BYTE;
		next_state = ST_PREAMBLE;
		if (next_pos == POS_W'(SFD_POS)) begin
			next_byte = SFD_BYTE;
			next_state = ST_SFD;
		end else if (next_pos == POS_W'(ETYPE_POS)) begin
			next_byte = ETHERTYPE_FGP[15:8];
			next_state = ST_ETYPE;
		end else if (next_pos == POS_W'(ETYPE_POS + 1)) begin
			next_byte = ETHERTYPE_FGP[7:0];
			next_state = ST_ETYPE;
		end else if (next_pos == POS_W'(FRAME_BYTES)) begin
			next_state = ST_GAP;
		end else if (next_pos >= POS_W'(PAYLOAD_POS)) begin
			next_byte = rd.rdata;
			next_state = ST_PAYLOAD;
		end
	end

	// Fetch on the third dibit so the byte is ready exactly at the byte boundary
	assign rd.rd = (state == ST_ETYPE || state == ST_PAYLOAD)
		&& dibit == DIB_W'(DIBITS_PER_BYTE - 2)
		&& next_pos >= POS_W'(PAYLOAD_POS)
		&& next_pos < POS_W'(FRAME_BYTES);
	assign rd.rd_idx = byte_idx_t'(next_pos - POS_W'(PAYLOAD_POS));
	assign rd.release_slot = release_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			byte_pos <= '0;
			dibit <= '0;
			release_q <= 1'b0;
		end else begin
			release_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rd.pending) begin
						state <= ST_PREAMBLE;
						byte_pos <= '0;
						dibit <= '0;
					end
				end
				ST_GAP: begin
					if (dibit == DIB_W'(GAP_LEN - 1)) begin
						state <= ST_IDLE;
						dibit <= '0;
					end else begin
						dibit <= dibit + 1'b1;
					end
				end
				default: begin
					// Wraps back to zero at the end of each byte
					dibit <= dibit + 1'b1;
					if (byte_end) begin
						byte_pos <= next_pos;
						state <= next_state;
						if (next_state == ST_GAP) begin
							release_q <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	// Dibit shifter, LSB pair goes out first
	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			shreg <= PREAMBLE_BYTE;
		end else if (byte_end) begin
			shreg <= next_byte;
		end else begin
			shreg <= {2'b00, shreg[7:2]};
		end
	end

	assign tx_en = state != ST_IDLE && state != ST_GAP;
	assign txd = tx_en ? shreg[1:0] : 2'b00;

endmodule

/* source/fgp_tx_pkg.sv */
package fgp_tx_pkg;

	// Packet geometry, one offset byte followed by the data bytes
	localparam int PACKET_LEN = 16;

	// One slot always stays empty so that head == tail means empty
	localparam int PB_QUEUE_LEN = 4;
	localparam int PB_RAM_SIZE = PACKET_LEN * PB_QUEUE_LEN;

	typedef logic [$clog2(PACKET_LEN)-1:0] byte_idx_t;
	typedef logic [$clog2(PB_QUEUE_LEN)-1:0] slot_t;

	// Buffer address, seen either as a plain RAM index or as slot and byte
	typedef union packed {
		logic [$clog2(PB_RAM_SIZE)-1:0] flat;
		struct packed {
			slot_t     slot;
			byte_idx_t idx;
		} fields;
	} pb_addr_u;

	// Frame lead-in
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam int PREAMBLE_LEN = 7;
	localparam logic [7:0] SFD_BYTE = 8'hD5;

	// Sent high byte first
	localparam logic [15:0] ETHERTYPE_FGP = 16'h88B5;

	// Preamble, SFD, EtherType and the packet itself
	localparam int FRAME_BYTES = PREAMBLE_LEN + 1 + 2 + PACKET_LEN;

	// RMII moves two bits per clock
	localparam int DIBITS_PER_BYTE = 4;

endpackage

/* source/fgp_tx_top.sv */
`timescale 1ns/1ps

module fgp_tx_top #(
	parameter int IDLE_LIMIT = 64
) (
	input  logic       clk,
	input  logic       rst,
	// Host byte stream, one byte per strobe
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	// RMII transmit
	output logic       tx_en,
	output logic [1:0] txd
);

	pb_write_if wr_if ();
	pb_read_if  rd_if ();

	// Host bytes into fixed-length packets
	packet_assembler #(
		.IDLE_LIMIT(IDLE_LIMIT)
	) u_assembler (
		.clk      (clk),
		.rst      (rst),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.wr       (wr_if.assembler)
	);

	// Ring of packet slots
	packet_buffer u_buffer (
		.clk (clk),
		.rst (rst),
		.wr  (wr_if.buffer),
		.rd  (rd_if.buffer)
	);

	// Queued packets out as RMII frames
	eth_tx_framer u_framer (
		.clk   (clk),
		.rst   (rst),
		.rd    (rd_if.framer),
		.tx_en (tx_en),
		.txd   (txd)
	);

endmodule

/* source/packet_assembler.sv */
`timescale 1ns/1ps

module packet_assembler
	import fgp_tx_pkg::*;
#(
	parameter int IDLE_LIMIT = 64
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	pb_write_if.assembler wr
);

	localparam int IDLE_W = $clog2(IDLE_LIMIT);

	byte_idx_t         byte_idx;
	logic [IDLE_W-1:0] idle_cnt;
	logic              last_byte;
	logic              idle_expired;

	assign last_byte = byte_idx == byte_idx_t'(PACKET_LEN - 1);

	// Only a partly received packet can time out
	assign idle_expired = !rx_valid && byte_idx != '0
		&& idle_cnt == IDLE_W'(IDLE_LIMIT - 1);

	// Every received byte goes straight into the buffer at the current index
	assign wr.we = rx_valid;
	assign wr.byte_idx = byte_idx;
	assign wr.wdata = rx_data;
	assign wr.commit = rx_valid && last_byte;

	always_ff @(posedge clk) begin
		if (rst) begin
			byte_idx <= '0;
		end else if (rx_valid) begin
			if (last_byte) begin
				byte_idx <= '0;
			end else begin
				byte_idx <= byte_idx + 1'b1;
			end
		end else if (idle_expired) begin
			// Drop the partial packet, the next byte starts a new one
			byte_idx <= '0;
		end
	end

	// Idle counter, counts quiet cycles in the middle of a packet
	always_ff @(posedge clk) begin
		if (rst) begin
			idle_cnt <= '0;
		end else if (rx_valid || byte_idx == '0 || idle_expired) begin
			idle_cnt <= '0;
		end else begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

endmodule

/* source/packet_buffer.sv */
`timescale 1ns/1ps

module packet_buffer
	import fgp_tx_pkg::*;
(
	input  logic clk,
	input  logic rst,
	pb_write_if.buffer wr,
	pb_read_if.buffer  rd
);

	logic [7:0] ram [PB_RAM_SIZE];

	// Tail is the slot being filled, head the slot being sent
	slot_t    head;
	slot_t    tail;
	slot_t    tail_next;
	logic     full;
	pb_addr_u waddr;
	pb_addr_u raddr;

	assign tail_next = tail + 1'b1;

	// Advancing the tail onto the head would make the ring look empty
	assign full = tail_next == head;

	assign rd.pending = head != tail;

	always_comb begin
		waddr.fields.slot = tail;
		waddr.fields.idx = wr.byte_idx;
	end

	// Reads always come from the head slot
	always_comb begin
		raddr.fields.slot = head;
		raddr.fields.idx = rd.rd_idx;
	end

	always_ff @(posedge clk) begin
		if (wr.we) begin
			ram[waddr.flat] <= wr.wdata;
		end
	end

	// Registered read port, data follows the strobe by one cycle
	always_ff @(posedge clk) begin
		if (rd.rd) begin
			rd.rdata <= ram[raddr.flat];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
		end else if (wr.commit && !full) begin
			tail <= tail_next;
		end
		// When full the tail stays put and the next packet overwrites this one
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
		end else if (rd.release_slot) begin
			head <= head + 1'b1;
		end
	end

endmodule

/* source/packet_buffer_if.sv */
`timescale 1ns/1ps

// Write side, from the packet assembler into the packet RAM
interface pb_write_if
	import fgp_tx_pkg::*;
();

	logic      we;
	byte_idx_t byte_idx;
	logic [7:0] wdata;
	// Comes together with the write of the last byte of a packet
	logic      commit;

	modport assembler (
		output we,
		output byte_idx,
		output wdata,
		output commit
	);

	modport buffer (
		input we,
		input byte_idx,
		input wdata,
		input commit
	);

endinterface

// Read side, from the head slot of the packet RAM into the framer
interface pb_read_if
	import fgp_tx_pkg::*;
();

	// Level, at least one packet is queued
	logic      pending;
	// Valid one cycle after rd
	logic [7:0] rdata;
	logic      rd;
	byte_idx_t rd_idx;
	// Pulse at the end of a frame, frees the head slot
	logic      release_slot;

	modport buffer (
		output pending,
		output rdata,
		input  rd,
		input  rd_idx,
		input  release_slot
	);

	modport framer (
		input  pending,
		input  rdata,
		output rd,
		output rd_idx,
		output release_slot
	);

endinterface

/* test/fgp_tx_checker.sv */
`timescale 1ns/1ps

module fgp_tx_checker
	import fgp_tx_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic rx_valid,
	input logic tx_en
);

	localparam int FRAME_CYCLES = FRAME_BYTES * DIBITS_PER_BYTE;

	logic       quiet;
	logic [7:0] run_len;
	logic [1:0] low_cnt;
	int         failures = 0;

	// Quiet until the first byte after reset
	// low_cnt saturates at three
	always_ff @(posedge clk) begin
		quiet <= rst || (quiet && !rx_valid);
		run_len <= (rst || !tx_en) ? 8'd0 : run_len + 8'd1;
		low_cnt <= (rst || tx_en) ? 2'd0 : low_cnt + {1'b0, low_cnt != 2'd3};
	end

	// No byte since reset, so there is nothing to send
	quiet_line: assert property (@(posedge clk) disable iff (rst) quiet |-> !tx_en) else begin
		failures = failures + 1;
		$error("tx_en went high with no input since reset");
	end

	frame_not_short: assert property (@(posedge clk) disable iff (rst)
		$fell(tx_en) |-> run_len == 8'(FRAME_CYCLES)) else begin
		failures = failures + 1;
		$error("tx_en high run ended after %0d cycles", $sampled(run_len));
	end

	frame_not_long: assert property (@(posedge clk) disable iff (rst)
		tx_en |-> run_len < 8'(FRAME_CYCLES)) else begin
		failures = failures + 1;
		$error("tx_en high run is longer than one frame");
	end

	min_gap: assert property (@(posedge clk) disable iff (rst)
		$rose(tx_en) |-> low_cnt >= 2'd2) else begin
		failures = failures + 1;
		$error("gap between frames shorter than two cycles");
	end

endmodule

bind fgp_tx_top fgp_tx_checker u_checker (
	.clk      (clk),
	.rst      (rst),
	.rx_valid (rx_valid),
	.tx_en    (tx_en)
);

/* test/fgp_tx_tb.sv */
`timescale 1ns/1ps

module fgp_tx_tb
	import fgp_tx_pkg::*;
();

	localparam int IDLE_LIMIT = 64;
	localparam int WAIT_LIMIT = 1000;

	logic        clk;
	logic        rst;
	logic        rx_valid;
	logic [7:0]  rx_data;
	logic        tx_en;
	logic [1:0]  txd;
	logic [31:0] lfsr;
	// Frame bytes still owed by the DUT, oldest first
	logic [7:0]  exp_q[$];
	logic [1:0]  dib_cnt;
	logic [7:0]  shift;
	int          check_errors;
	int          timeout_errors;

	fgp_tx_top #(
		.IDLE_LIMIT(IDLE_LIMIT)
	) dut (
		.clk      (clk),
		.rst      (rst),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.tx_en    (tx_en),
		.txd      (txd)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = (lfsr >> 1) ^ (out ? 32'h80200003 : 32'h0);
		return out;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {lfsr_bit(), b[7:1]};
		end
		return b;
	endfunction

	function automatic void fail_check(input string msg);
		check_errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endfunction

	task automatic compare_byte(input logic [7:0] got);
		logic [7:0] want;
		assert (exp_q.size() > 0) else fail_check($sformatf("byte %02h sent with no frame due", got));
		if (exp_q.size() > 0) begin
			want = exp_q.pop_front();
			assert (got == want) else fail_check($sformatf("got %02h, expected %02h", got, want));
		end
	endtask

	// First dibit on the wire is the least significant pair
	always @(negedge clk) begin
		if (rst || !tx_en) begin
			assert (rst || dib_cnt == 2'd0) else fail_check("tx_en fell in the middle of a byte");
			dib_cnt <= 2'd0;
		end else begin
			shift <= {txd, shift[7:2]};
			dib_cnt <= dib_cnt + 2'd1;
			if (dib_cnt == 2'd3) begin
				compare_byte({txd, shift[7:2]});
			end
		end
	end

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		rx_valid <= 1'b1;
		rx_data <= b;
	endtask

	task automatic stop_input();
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	// A packet that fits in the ring owes a whole frame
	task automatic send_packet(input logic keep);
		logic [7:0] b;
		if (keep) begin
			repeat (7) exp_q.push_back(8'h55);
			exp_q.push_back(8'hD5);
			exp_q.push_back(8'h88);
			exp_q.push_back(8'hB5);
		end
		for (int i = 0; i < PACKET_LEN; i++) begin
			b = random_byte();
			if (keep) begin
				exp_q.push_back(b);
			end
			send_byte(b);
		end
	endtask

	task automatic wait_frames_sent();
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || tx_en) && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0 || tx_en) begin
			timeout_errors++;
			$display("Timeout at %0t: %0d expected frame bytes were never sent", $time,
				exp_q.size());
			exp_q.delete();
		end
	endtask

	task automatic expect_silence(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			assert (!tx_en) else fail_check("tx_en high while no frame is due");
		end
	endtask

	initial begin
		lfsr = 32'd89132;
		check_errors = 0;
		timeout_errors = 0;
		rst = 1'b1;
		rx_valid = 1'b0;
		rx_data = 8'h00;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		expect_silence(120);

		// One packet, one frame
		send_packet(1'b1);
		stop_input();
		wait_frames_sent();
		expect_silence(20);

		// Partial packet left to time out, then a full one
		repeat (5) send_byte(random_byte());
		stop_input();
		expect_silence(IDLE_LIMIT + 10);
		send_packet(1'b1);
		stop_input();
		wait_frames_sent();
		expect_silence(150);

		// Six packets in a row, the ring holds three
		for (int i = 0; i < 6; i++) begin
			send_packet(i < 3);
		end
		stop_input();
		wait_frames_sent();
		expect_silence(200);

		// Two packets queued together
		send_packet(1'b1);
		send_packet(1'b1);
		stop_input();
		wait_frames_sent();
		expect_silence(20);

		$display("Errors: %0d check, %0d timeout, %0d protocol", check_errors, timeout_errors,
			dut.u_checker.failures);
		if (check_errors + timeout_errors + dut.u_checker.failures == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
